// File: hw/coherence_params.svh
`ifndef COHERENCE_PARAMS_SVH
`define COHERENCE_PARAMS_SVH

// data and address widths
`define WORD_W 32
`define ADDR_W 32

// two cores, two words per block
`define CPUS 2
`define BLOCK_WORDS 2

`endif

// File: hw/coherence_pkg.sv
`include "coherence_params.svh"

package coherence_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`ADDR_W-1:0] addr_t;
    // selects one of the two cores
    typedef logic [$clog2(`CPUS)-1:0] cpuId_t;

    typedef enum logic [1:0] {
        FREE, BUSY, ACCESS, ERROR
    } ramState_t;

    // kind of transaction held by the arbiter
    typedef enum logic [2:0] {
        NONE, IFETCH, READ, READX, WRITEBACK
    } reqKind_t;

    typedef enum logic [2:0] {
        IDLE, SNOOP, FLUSH, FILL, WBACK, FETCH
    } busState_t;

endpackage

// File: hw/busArbiter.sv
`include "coherence_params.svh"

module busArbiter (
    input  logic CLK,
    input  logic nRST,
    input  logic [`CPUS-1:0] iREN,
    input  logic [`CPUS-1:0] dREN,
    input  logic [`CPUS-1:0] dWEN,
    input  logic [`CPUS-1:0] cctrans,
    input  coherence_pkg::addr_t [`CPUS-1:0] iaddr,
    input  coherence_pkg::addr_t [`CPUS-1:0] daddr,
    input  logic releaseReq,
    output coherence_pkg::reqKind_t reqKind,
    output coherence_pkg::cpuId_t reqCpu,
    output coherence_pkg::addr_t reqAddr
);
    import coherence_pkg::*;

    reqKind_t pickKind;
    cpuId_t pickCpu;
    addr_t pickAddr;

    // a write with cctrans set is an eviction, without it a write miss
    function automatic reqKind_t dataKind(input logic ren, input logic trans);
        if (ren) begin
            return READ;
        end
        return trans ? WRITEBACK : READX;
    endfunction

    // fixed priority: dcache 0, dcache 1, icache 0, icache 1
    always_comb begin
        pickKind = NONE;
        pickCpu = cpuId_t'(0);
        pickAddr = '0;
        if (dREN[0] || dWEN[0]) begin
            pickKind = dataKind(dREN[0], cctrans[0]);
            pickAddr = daddr[0];
        end else if (dREN[1] || dWEN[1]) begin
            pickKind = dataKind(dREN[1], cctrans[1]);
            pickCpu = cpuId_t'(1);
            pickAddr = daddr[1];
        end else if (iREN[0]) begin
            pickKind = IFETCH;
            pickAddr = iaddr[0];
        end else if (iREN[1]) begin
            pickKind = IFETCH;
            pickCpu = cpuId_t'(1);
            pickAddr = iaddr[1];
        end
    end

    // grant stays put until the FSM finishes the transaction
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            reqKind <= NONE;
            reqCpu <= cpuId_t'(0);
        end else if (releaseReq) begin
            reqKind <= NONE;
        end else if (reqKind == NONE) begin
            reqKind <= pickKind;
            reqCpu <= pickCpu;
        end
    end

    always_ff @(posedge CLK) begin
        if (reqKind == NONE) begin
            reqAddr <= pickAddr;
        end
    end

endmodule

// File: hw/busFsm.sv
`include "coherence_params.svh"

module busFsm (
    input  logic CLK,
    input  logic nRST,
    input  coherence_pkg::reqKind_t reqKind,
    input  logic otherHas,
    input  logic otherDirty,
    input  logic wordDone,
    output coherence_pkg::busState_t state,
    output logic lastWord,
    output logic snoopEn,
    output logic invEn,
    output logic releaseReq
);
    import coherence_pkg::*;

    typedef logic [$clog2(`BLOCK_WORDS)-1:0] wordIdx_t;

    busState_t nextState;
    wordIdx_t wordCnt;

    // fetch moves a single word, block phases move BLOCK_WORDS
    assign lastWord = (state == FETCH) || (wordCnt == wordIdx_t'(`BLOCK_WORDS - 1));

    // transaction ends with the requester's last word
    assign releaseReq = wordDone && lastWord
        && (state == FILL || state == WBACK || state == FETCH);

    // other cache stays stalled from the snoop to the end of the fill
    assign snoopEn = (state == SNOOP) || (state == FLUSH) || (state == FILL);

    // write miss kills the other copy with the final fill word
    assign invEn = (state == FILL) && (reqKind == READX) && lastWord;

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                case (reqKind)
                    READ, READX: nextState = SNOOP;
                    WRITEBACK:   nextState = WBACK;
                    IFETCH:      nextState = FETCH;
                    default:     nextState = IDLE;
                endcase
            end
            SNOOP: begin
                // one cycle, reply is live here
                if (otherHas && otherDirty) begin
                    nextState = FLUSH;
                end else begin
                    nextState = FILL;
                end
            end
            FLUSH: begin
                if (wordDone && lastWord) begin
                    nextState = FILL;
                end
            end
            FILL, WBACK, FETCH: begin
                if (releaseReq) begin
                    nextState = IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            wordCnt <= '0;
        end else begin
            state <= nextState;
            // counter wraps at the end of every phase
            if (wordDone) begin
                wordCnt <= lastWord ? '0 : wordCnt + 1'b1;
            end
        end
    end

endmodule

// File: hw/snoopPort.sv
`include "coherence_params.svh"

module snoopPort (
    input  logic CLK,
    input  logic nRST,
    input  logic snoopEn,
    input  logic invEn,
    input  coherence_pkg::cpuId_t reqCpu,
    input  coherence_pkg::addr_t [`CPUS-1:0] daddr,
    input  logic [`CPUS-1:0] cctrans,
    input  logic [`CPUS-1:0] ccwrite,
    output logic [`CPUS-1:0] ccwait,
    output coherence_pkg::addr_t [`CPUS-1:0] ccsnoopaddr,
    output logic [`CPUS-1:0] ccinv,
    output logic otherHas,
    output logic otherDirty
);
    import coherence_pkg::*;

    cpuId_t other;
    logic captured;
    logic hasQ;
    logic dirtyQ;

    assign other = ~reqCpu;

    // only the non-requesting core is snooped
    always_comb begin
        for (int c = 0; c < `CPUS; c++) begin
            ccwait[c] = snoopEn && (cpuId_t'(c) == other);
            ccinv[c] = invEn && (cpuId_t'(c) == other);
            ccsnoopaddr[c] = ccwait[c] ? daddr[reqCpu] : '0;
        end
    end

    // reply sampled once, in the first snoop cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            captured <= 1'b0;
            hasQ <= 1'b0;
            dirtyQ <= 1'b0;
        end else if (!snoopEn) begin
            captured <= 1'b0;
        end else if (!captured) begin
            captured <= 1'b1;
            hasQ <= cctrans[other];
            dirtyQ <= ccwrite[other];
        end
    end

    // live answer during SNOOP so the FSM branches without an extra cycle
    assign otherHas = captured ? hasQ : (snoopEn && cctrans[other]);
    assign otherDirty = captured ? dirtyQ : (snoopEn && ccwrite[other]);

endmodule

// File: hw/memPort.sv
`include "coherence_params.svh"

module memPort (
    input  coherence_pkg::busState_t state,
    input  coherence_pkg::cpuId_t reqCpu,
    input  logic lastWord,
    input  logic [`CPUS-1:0] iREN,
    input  logic [`CPUS-1:0] dREN,
    input  logic [`CPUS-1:0] dWEN,
    input  coherence_pkg::addr_t [`CPUS-1:0] iaddr,
    input  coherence_pkg::addr_t [`CPUS-1:0] daddr,
    input  coherence_pkg::word_t [`CPUS-1:0] dstore,
    input  coherence_pkg::word_t ramload,
    input  coherence_pkg::ramState_t ramstate,
    output logic ramREN,
    output logic ramWEN,
    output coherence_pkg::addr_t ramaddr,
    output coherence_pkg::word_t ramstore,
    output coherence_pkg::word_t [`CPUS-1:0] iload,
    output coherence_pkg::word_t [`CPUS-1:0] dload,
    output logic [`CPUS-1:0] iwait,
    output logic [`CPUS-1:0] dwait,
    output logic wordDone
);
    import coherence_pkg::*;

    cpuId_t other;
    logic snooped;

    assign other = ~reqCpu;

    // other cache is stalled from the snoop to the end of the fill
    assign snooped = (state == SNOOP) || (state == FLUSH) || (state == FILL);

    always_comb begin
        ramREN = 1'b0;
        ramWEN = 1'b0;
        ramaddr = '0;
        ramstore = '0;
        case (state)
            // snooped cache supplies its own address and data
            FLUSH: begin
                ramWEN = 1'b1;
                ramaddr = daddr[other];
                ramstore = dstore[other];
            end
            FILL: begin
                ramREN = 1'b1;
                ramaddr = daddr[reqCpu];
            end
            WBACK: begin
                ramWEN = 1'b1;
                ramaddr = daddr[reqCpu];
                ramstore = dstore[reqCpu];
            end
            FETCH: begin
                ramREN = 1'b1;
                ramaddr = iaddr[reqCpu];
            end
            default: begin
            end
        endcase
    end

    assign wordDone = (ramREN || ramWEN) && (ramstate == ACCESS);

    always_comb begin
        for (int c = 0; c < `CPUS; c++) begin
            iload[c] = (state == FETCH && reqCpu == cpuId_t'(c)) ? ramload : '0;
            dload[c] = (state == FILL && reqCpu == cpuId_t'(c)) ? ramload : '0;
            // fetch ends on its only word
            iwait[c] = iREN[c] && !(wordDone && lastWord && state == FETCH
                && reqCpu == cpuId_t'(c));
            // while ccwait is high a low dwait marks a flushed word
            dwait[c] = (dREN[c] || dWEN[c] || (snooped && other == cpuId_t'(c)))
                && !(wordDone && ((state == FLUSH && other == cpuId_t'(c))
                || ((state == FILL || state == WBACK) && reqCpu == cpuId_t'(c))));
        end
    end

endmodule

// File: hw/coherenceBus.sv
`include "coherence_params.svh"

module coherenceBus (
    input  logic CLK,
    input  logic nRST,
    input  logic [`CPUS-1:0] iREN,
    input  logic [`CPUS-1:0] dREN,
    input  logic [`CPUS-1:0] dWEN,
    input  coherence_pkg::addr_t [`CPUS-1:0] iaddr,
    input  coherence_pkg::addr_t [`CPUS-1:0] daddr,
    input  coherence_pkg::word_t [`CPUS-1:0] dstore,
    input  logic [`CPUS-1:0] cctrans,
    input  logic [`CPUS-1:0] ccwrite,
    output logic [`CPUS-1:0] iwait,
    output logic [`CPUS-1:0] dwait,
    output coherence_pkg::word_t [`CPUS-1:0] iload,
    output coherence_pkg::word_t [`CPUS-1:0] dload,
    output logic [`CPUS-1:0] ccwait,
    output coherence_pkg::addr_t [`CPUS-1:0] ccsnoopaddr,
    output logic [`CPUS-1:0] ccinv,
    output logic ramREN,
    output logic ramWEN,
    output coherence_pkg::addr_t ramaddr,
    output coherence_pkg::word_t ramstore,
    input  coherence_pkg::word_t ramload,
    input  coherence_pkg::ramState_t ramstate
);
    import coherence_pkg::*;

    reqKind_t reqKind;
    cpuId_t reqCpu;
    busState_t state;
    logic lastWord;
    logic snoopEn;
    logic invEn;
    logic releaseReq;
    logic otherHas;
    logic otherDirty;
    logic wordDone;

    busArbiter busArbiter_inst (
        .CLK(CLK), .nRST(nRST), .iREN(iREN), .dREN(dREN), .dWEN(dWEN),
        .cctrans(cctrans), .iaddr(iaddr), .daddr(daddr), .releaseReq(releaseReq),
        .reqKind(reqKind), .reqCpu(reqCpu), .reqAddr()
    );

    busFsm busFsm_inst (
        .CLK(CLK), .nRST(nRST), .reqKind(reqKind), .otherHas(otherHas),
        .otherDirty(otherDirty), .wordDone(wordDone), .state(state),
        .lastWord(lastWord), .snoopEn(snoopEn), .invEn(invEn), .releaseReq(releaseReq)
    );

    snoopPort snoopPort_inst (
        .CLK(CLK), .nRST(nRST), .snoopEn(snoopEn), .invEn(invEn), .reqCpu(reqCpu),
        .daddr(daddr), .cctrans(cctrans), .ccwrite(ccwrite), .ccwait(ccwait),
        .ccsnoopaddr(ccsnoopaddr), .ccinv(ccinv), .otherHas(otherHas),
        .otherDirty(otherDirty)
    );

    memPort memPort_inst (
        .state(state), .reqCpu(reqCpu), .lastWord(lastWord), .iREN(iREN),
        .dREN(dREN), .dWEN(dWEN), .iaddr(iaddr), .daddr(daddr), .dstore(dstore),
        .ramload(ramload), .ramstate(ramstate), .ramREN(ramREN), .ramWEN(ramWEN),
        .ramaddr(ramaddr), .ramstore(ramstore), .iload(iload), .dload(dload),
        .iwait(iwait), .dwait(dwait), .wordDone(wordDone)
    );

endmodule

// File: dv/coherenceBus_sva.sv
`include "coherence_params.svh"

module coherenceBus_sva (
    input logic CLK,
    input logic nRST,
    input logic ramREN,
    input logic ramWEN,
    input logic [`CPUS-1:0] ccwait,
    input logic [`CPUS-1:0] ccinv,
    input logic [`CPUS-1:0] iwait,
    input logic [`CPUS-1:0] dwait
);
    timeunit 1ns;
    timeprecision 1ps;

    // RAM is read or written, never both
    ramOneDir: assert property (@(posedge CLK) disable iff (!nRST) !(ramREN && ramWEN))
        else $error("ramREN and ramWEN high together");

    // invalidate only reaches a stalled cache
    invUnderWait: assert property (@(posedge CLK) disable iff (!nRST)
        (ccinv & ~ccwait) == '0)
        else $error("ccinv without ccwait");

    // first cycle out of reset
    quietAfterReset: assert property (@(posedge CLK) $rose(nRST) |->
        !ramREN && !ramWEN && ccwait == '0 && ccinv == '0 && iwait == '0 && dwait == '0)
        else $error("control output active right after reset");

endmodule

bind coherenceBus coherenceBus_sva coherenceBus_sva_inst (
    .CLK(CLK), .nRST(nRST), .ramREN(ramREN), .ramWEN(ramWEN),
    .ccwait(ccwait), .ccinv(ccinv), .iwait(iwait), .dwait(dwait)
);

// File: dv/coherenceBus_tb.sv
`include "coherence_params.svh"

module coherenceBus_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import coherence_pkg::*;

    localparam int TESTS = 6;
    localparam int TIMEOUT_NS = TESTS * 200 * 10;

    logic CLK, nRST;
    logic [`CPUS-1:0] iREN, dREN, dWEN, cctrans, ccwrite;
    logic [`CPUS-1:0] iwait, dwait, ccwait, ccinv;
    addr_t [`CPUS-1:0] iaddr, daddr, ccsnoopaddr;
    word_t [`CPUS-1:0] dstore, iload, dload;
    logic ramREN, ramWEN;
    addr_t ramaddr;
    word_t ramstore, ramload;
    ramState_t ramstate;

    word_t mem [0:255];
    int cycle = 0;
    int invCount [`CPUS];
    int waitCount [`CPUS];

    coherenceBus coherenceBus_inst (.*);

    // RAM read data follows the address
    assign ramload = mem[ramaddr[9:2]];

    function automatic word_t fillPattern(input addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'h3C5A_0F96;
    endfunction

    function automatic word_t memWord(input addr_t a);
        return mem[a[9:2]];
    endfunction

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped on first failure");
    endtask

    task automatic checkWord(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("ERROR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkAddr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("ERROR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkTrue(input logic ok, input string what);
        if (ok !== 1'b1) begin
            stopRun(what);
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) cycle <= cycle + 1;

    // RAM model, random latency of 0 to 3 cycles per word
    initial begin
        int delay;
        logic hit, wen;
        addr_t a;
        word_t d;
        void'($urandom(62267));
        for (int i = 0; i < 256; i++) begin
            mem[i] = fillPattern(addr_t'(i * 4));
        end
        ramstate = FREE;
        delay = 0;
        forever begin
            @(negedge CLK);
            hit = (ramREN || ramWEN) && ramstate == ACCESS;
            wen = ramWEN;
            a = ramaddr;
            d = ramstore;
            @(posedge CLK);
            if (hit) begin
                if (wen) begin
                    mem[a[9:2]] = d;
                end
                delay = $urandom % 4;
            end
            #1;
            if (ramREN || ramWEN) begin
                if (delay == 0) begin
                    ramstate = ACCESS;
                end else begin
                    ramstate = BUSY;
                    delay--;
                end
            end else begin
                ramstate = FREE;
            end
        end
    end

    // snoop monitor
    initial begin
        for (int c = 0; c < `CPUS; c++) begin
            invCount[c] = 0;
            waitCount[c] = 0;
        end
        forever begin
            @(negedge CLK);
            for (int c = 0; c < `CPUS; c++) begin
                if (ccwait[c]) begin
                    waitCount[c]++;
                    checkAddr(ccsnoopaddr[c], daddr[1 - c], "ccsnoopaddr");
                end
                if (ccinv[c]) begin
                    invCount[c]++;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: a bus transaction never completed");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    task automatic fetch(input cpuId_t cpu, input addr_t addr, output int doneCycle);
        logic done;
        done = 1'b0;
        doneCycle = 0;
        iREN[cpu] = 1'b1;
        iaddr[cpu] = addr;
        while (!done) begin
            @(negedge CLK);
            if (!iwait[cpu]) begin
                checkWord(iload[cpu], memWord(addr), "iload");
                done = 1'b1;
                doneCycle = cycle;
            end
            @(posedge CLK);
            #1;
        end
        iREN[cpu] = 1'b0;
    endtask

    task automatic dataAccess(input cpuId_t cpu, input logic write, input logic evict,
        input addr_t base, input word_t [1:0] st, output word_t [1:0] got,
        output int doneCycle);
        int idx;
        logic done;
        idx = 0;
        got = '0;
        doneCycle = 0;
        dREN[cpu] = !write;
        dWEN[cpu] = write;
        cctrans[cpu] = evict;
        daddr[cpu] = base;
        dstore[cpu] = st[0];
        while (idx < `BLOCK_WORDS) begin
            @(negedge CLK);
            done = !dwait[cpu];
            if (done) begin
                got[idx] = dload[cpu];
                doneCycle = cycle;
            end
            @(posedge CLK);
            #1;
            if (done) begin
                idx++;
                // cache steps to the next word itself
                daddr[cpu] = base + addr_t'(4 * idx);
                dstore[cpu] = st[idx % `BLOCK_WORDS];
            end
        end
        dREN[cpu] = 1'b0;
        dWEN[cpu] = 1'b0;
        cctrans[cpu] = 1'b0;
    endtask

    // snooped cache pushing its modified block out
    task automatic flushBlock(input cpuId_t cpu, input addr_t base, input word_t [1:0] line);
        int idx;
        logic done;
        idx = 0;
        daddr[cpu] = base;
        dstore[cpu] = line[0];
        while (idx < `BLOCK_WORDS) begin
            @(negedge CLK);
            done = ccwait[cpu] && !dwait[cpu];
            @(posedge CLK);
            #1;
            if (done) begin
                idx++;
                daddr[cpu] = base + addr_t'(4 * idx);
                dstore[cpu] = line[idx % `BLOCK_WORDS];
            end
        end
    endtask

    task automatic testFetch();
        int dc;
        fetch(1'b0, 32'h0000_0040, dc);
        fetch(1'b1, 32'h0000_0084, dc);
    endtask

    task automatic testReadClean();
        word_t [1:0] got;
        int seen, inv, dc;
        cctrans[1] = 1'b1;
        ccwrite[1] = 1'b0;
        seen = waitCount[1];
        inv = invCount[1];
        dataAccess(1'b0, 1'b0, 1'b0, 32'h0000_0100, '0, got, dc);
        checkWord(got[0], memWord(32'h0000_0100), "clean read word 0");
        checkWord(got[1], memWord(32'h0000_0104), "clean read word 1");
        checkTrue(waitCount[1] > seen, "core 1 was never snooped on a read miss");
        checkTrue(invCount[1] == inv, "ccinv was raised on a plain read miss");
        cctrans[1] = 1'b0;
    endtask

    task automatic testReadDirty();
        word_t [1:0] line, got;
        int dc;
        line = {32'hD00D_0002, 32'hD00D_0001};
        cctrans[0] = 1'b1;
        ccwrite[0] = 1'b1;
        fork
            dataAccess(1'b1, 1'b0, 1'b0, 32'h0000_0200, '0, got, dc);
            flushBlock(1'b0, 32'h0000_0200, line);
        join
        checkWord(memWord(32'h0000_0200), line[0], "flushed word 0 in memory");
        checkWord(memWord(32'h0000_0204), line[1], "flushed word 1 in memory");
        checkWord(got[0], line[0], "fill word 0 after flush");
        checkWord(got[1], line[1], "fill word 1 after flush");
        cctrans[0] = 1'b0;
        ccwrite[0] = 1'b0;
    endtask

    task automatic testReadExclusive();
        word_t [1:0] got;
        int inv, dc;
        cctrans[1] = 1'b1;
        inv = invCount[1];
        dataAccess(1'b0, 1'b1, 1'b0, 32'h0000_0300, '0, got, dc);
        checkWord(got[0], memWord(32'h0000_0300), "read-exclusive word 0");
        checkWord(got[1], memWord(32'h0000_0304), "read-exclusive word 1");
        checkTrue(invCount[1] > inv, "core 1 was not invalidated on a write miss");
        cctrans[1] = 1'b0;
    endtask

    task automatic testWriteback();
        word_t [1:0] st, got;
        int seen, dc;
        st = {32'hBEEF_0002, 32'hBEEF_0001};
        seen = waitCount[0] + waitCount[1];
        dataAccess(1'b1, 1'b1, 1'b1, 32'h0000_02C0, st, got, dc);
        checkWord(memWord(32'h0000_02C0), st[0], "writeback word 0 in memory");
        checkWord(memWord(32'h0000_02C4), st[1], "writeback word 1 in memory");
        checkTrue(waitCount[0] + waitCount[1] == seen, "a writeback snooped a cache");
    endtask

    task automatic testPriority();
        word_t [1:0] got0, got1;
        int dataDone, fetchDone, done0, done1;
        fork
            dataAccess(1'b1, 1'b0, 1'b0, 32'h0000_0380, '0, got1, dataDone);
            fetch(1'b0, 32'h0000_03C0, fetchDone);
        join
        checkTrue(dataDone < fetchDone, "instruction fetch of core 0 beat data of core 1");
        fork
            dataAccess(1'b0, 1'b0, 1'b0, 32'h0000_0180, '0, got0, done0);
            dataAccess(1'b1, 1'b0, 1'b0, 32'h0000_01C0, '0, got1, done1);
        join
        checkTrue(done0 < done1, "data read of core 1 beat data read of core 0");
        checkWord(got0[1], memWord(32'h0000_0184), "core 0 read word 1");
        checkWord(got1[1], memWord(32'h0000_01C4), "core 1 read word 1");
    endtask

    initial begin
        nRST = 1'b0;
        iREN = '0;
        dREN = '0;
        dWEN = '0;
        cctrans = '0;
        ccwrite = '0;
        iaddr = '0;
        daddr = '0;
        dstore = '0;
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;
        repeat (2) @(posedge CLK);
        #1;
        testFetch();
        testReadClean();
        testReadDirty();
        testReadExclusive();
        testWriteback();
        testPriority();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hw
hw/coherence_pkg.sv
hw/busArbiter.sv
hw/busFsm.sv
hw/snoopPort.sv
hw/memPort.sv
hw/coherenceBus.sv
dv/coherenceBus_sva.sv
dv/coherenceBus_tb.sv

// File: Makefile
BIN := obj_dir/VcoherenceBus_tb
SRCS := $(filter-out +%,$(shell cat vlog.f)) hw/coherence_params.svh

.PHONY: run clean

run: $(BIN)
	./$(BIN) | awk '{ print } /^PASS: all tests$$/ { ok = 1 } END { exit !ok }'

$(BIN): $(SRCS) vlog.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module coherenceBus_tb -f vlog.f -o VcoherenceBus_tb

clean:
	rm -rf obj_dir
